// ==== design/nes_cart_pkg.sv ====
// Shared constants and types for the cartridge loader and controller path
// Imported by the RTL blocks and by the testbench

package nes_cart_pkg;

  // iNES header
  localparam int HDR_BYTES = 16;
  localparam logic [0:3][7:0] INES_MAGIC = {8'h4E, 8'h45, 8'h53, 8'h1A};  // "NES" + EOF

  // External memory map
  localparam int MEM_ADDR_W = 22;
  localparam logic [MEM_ADDR_W-1:0] PRG_BASE = 22'h000000;
  localparam logic [MEM_ADDR_W-1:0] CHR_BASE = 22'h200000;
  localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB pages
  localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB pages

  // Console memory slot, one cycle in four
  localparam int SLOT_PHASES = 4;
  localparam int SLOT_PHASE_W = $clog2(SLOT_PHASES);

  // Reset stretch after a download
  localparam int DL_RESET_CYCLES = 255;
  localparam int DL_CNT_W = $clog2(DL_RESET_CYCLES + 1);

  typedef enum logic [1:0] {
    HEADER,    // Collecting 16 header bytes
    LOAD_PRG,  // Streaming PRG ROM
    LOAD_CHR,  // Streaming CHR ROM
    FAILED     // Bad magic or trainer present
  } loader_state_e;

  // Cartridge configuration word handed to the console
  typedef struct packed {
    logic [14:0] spare;
    logic        four_screen;
    logic        chr_ram;
    logic        mirroring;
    logic [2:0]  chr_size;   // log2 of CHR pages, saturated
    logic [2:0]  prg_size;   // log2 of PRG pages, saturated
    logic [7:0]  mapper;
  } cart_flags_t;

endpackage

// ==== design/load_mem_if.sv ====
// Loader write request and status toward the memory port and reset control
// Loader drives everything, the other two blocks only listen

`timescale 1ns/10ps

interface load_mem_if import nes_cart_pkg::*; ();

  logic [MEM_ADDR_W-1:0] addr;   // Write address
  logic [7:0]            data;   // Write data
  logic                  write;  // One cycle per accepted byte
  logic                  error;  // Load failed

  modport loader (
    output addr, data, write, error
  );

  // Memory slot side
  modport port (
    input addr, data, write
  );

  // Reset controller only needs the failure flag
  modport ctrl (
    input error
  );

endinterface

// ==== design/ines_game_loader.sv ====
// Parses the iNES header from a byte stream and issues PRG then CHR writes
// Runs only while its reset is low; done stays high until the next reset

`timescale 1ns/10ps

module ines_game_loader import nes_cart_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  indata,
  input  logic        indata_clk,        // One-cycle byte strobe
  input  logic        invert_mirroring,
  load_mem_if.loader  mem,
  output logic        done,
  output cart_flags_t flags
);

  loader_state_e         state;
  logic [3:0]            hdr_idx;          // Next header slot
  logic [7:0]            ines [HDR_BYTES]; // Stored header
  logic [MEM_ADDR_W-1:0] wr_addr;
  logic [MEM_ADDR_W-1:0] bytes_left;       // Bytes still due in this section
  logic                  failed;
  logic                  magic_ok;
  logic                  extra_nz;         // Any of bytes 8..15 set
  logic                  is_dirty;
  logic [7:0]            prg_pages;
  logic [7:0]            chr_pages;

  // Smallest n with pages <= 2^n, capped at 7
  function automatic logic [2:0] size_code(input logic [7:0] pages);
    logic [2:0] code;
    code = 3'd7;
    for (int n = 6; n >= 0; n--) begin
      if ({1'b0, pages} <= (9'd1 << n))
        code = 3'(n);
    end
    return code;
  endfunction

  assign prg_pages = ines[4];
  assign chr_pages = ines[5];

  assign mem.addr  = wr_addr;
  assign mem.data  = indata;  // Byte goes straight through with its strobe
  assign mem.write = indata_clk && (bytes_left != '0) &&
                     (state == LOAD_PRG || state == LOAD_CHR);
  assign mem.error = failed;

  // Header store
  always_ff @(posedge clk) begin
    if (!reset && state == HEADER && indata_clk)
      ines[hdr_idx] <= indata;
  end

  always_comb begin
    magic_ok = 1'b1;
    extra_nz = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (ines[i] != INES_MAGIC[i])
        magic_ok = 1'b0;
    end
    for (int i = 8; i < HDR_BYTES; i++) begin
      extra_nz = extra_nz | (ines[i] != 8'h00);
    end
    // Junk in 8..15 without the iNES 2.0 marker means byte 7 is garbage too
    is_dirty = (ines[7][3:2] != 2'b10) && extra_nz;

    flags.spare       = '0;
    flags.four_screen = ines[6][3];
    flags.chr_ram     = (chr_pages == 8'h00);
    flags.mirroring   = ines[6][0] ^ invert_mirroring;
    flags.chr_size    = size_code(chr_pages);
    flags.prg_size    = size_code(prg_pages);
    flags.mapper      = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= HEADER;
      hdr_idx    <= '0;
      wr_addr    <= PRG_BASE;
      bytes_left <= '0;
      done       <= 1'b0;
      failed     <= 1'b0;
    end else begin
      case (state)
        HEADER: begin
          if (indata_clk) begin
            hdr_idx <= hdr_idx + 4'd1;
            if (hdr_idx == 4'(HDR_BYTES - 1)) begin
              // Byte 4 is already stored by now
              bytes_left <= MEM_ADDR_W'(prg_pages) << PRG_PAGE_SHIFT;
              // Trainers are not supported
              state <= (magic_ok && !ines[6][2]) ? LOAD_PRG : FAILED;
            end
          end
        end
        LOAD_PRG, LOAD_CHR: begin
          if (bytes_left != '0) begin
            if (indata_clk) begin
              bytes_left <= bytes_left - 1'b1;
              wr_addr    <= wr_addr + 1'b1;
            end
          end else if (state == LOAD_PRG) begin
            state      <= LOAD_CHR;  // PRG finished, CHR follows
            wr_addr    <= CHR_BASE;
            bytes_left <= MEM_ADDR_W'(chr_pages) << CHR_PAGE_SHIFT;
          end else begin
            done <= 1'b1;             // Whole image in memory
          end
        end
        FAILED: begin
          done   <= 1'b1;
          failed <= 1'b1;
        end
        default: state <= HEADER;
      endcase
    end
  end

endmodule

// ==== design/loader_mem_port.sv ====
// Holds loader writes until the console memory slot and muxes them with
// the console's own requests toward external memory

`timescale 1ns/10ps

module loader_mem_port import nes_cart_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_nes,
  load_mem_if.port              ld,
  input  logic                  downloading,
  input  logic [MEM_ADDR_W-1:0] cpu_addr,
  input  logic [7:0]            cpu_dout,
  input  logic                  cpu_write,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic [7:0]            mem_din,
  output logic                  mem_we,
  output logic                  slot_run
);

  logic [SLOT_PHASE_W-1:0] phase;     // Free running slot phase
  logic                    pending;   // Held write not yet issued
  logic                    slot_we;
  logic [MEM_ADDR_W-1:0]   hold_addr;
  logic [7:0]              hold_data;

  assign slot_run = (phase == SLOT_PHASE_W'(SLOT_PHASES - 1));  // Console clock enable

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      phase   <= '0;
      pending <= 1'b0;
      slot_we <= 1'b0;
    end else begin
      phase <= phase + 1'b1;
      if (slot_run) begin
        slot_we <= pending || ld.write;  // Strobe in the last phase goes out at once
        pending <= 1'b0;
      end else begin
        slot_we <= 1'b0;
        if (ld.write)
          pending <= 1'b1;
      end
    end
  end

  // Later strobe in the same slot simply overwrites
  always_ff @(posedge clk) begin
    if (ld.write) begin
      hold_addr <= ld.addr;
      hold_data <= ld.data;
    end
  end

  // Loader owns memory only during a download
  assign mem_addr = downloading ? hold_addr : cpu_addr;
  assign mem_din  = downloading ? hold_data : cpu_dout;
  assign mem_we   = downloading ? slot_we : cpu_write;

endmodule

// ==== design/core_reset_control.sv ====
// Console reset generation and cartridge configuration latch
// Keeps the core in reset before the first download and after each one

`timescale 1ns/10ps

module core_reset_control import nes_cart_pkg::*; (
  input  logic        clk,
  input  logic        reset_nes,
  input  logic        downloading,
  input  logic        user_reset,
  load_mem_if.ctrl    ld,
  input  logic        done,
  input  cart_flags_t flags,
  output logic        loader_reset,
  output logic        core_reset,
  output cart_flags_t cart_flags
);

  logic [DL_CNT_W-1:0] dl_cnt;      // Post-download countdown
  logic                download_reset;
  logic                init_reset;  // Until the first download starts

  // Reload while downloading, count down after
  always_ff @(posedge clk) begin
    if (reset_nes)
      dl_cnt <= '0;
    else if (downloading)
      dl_cnt <= DL_CNT_W'(DL_RESET_CYCLES);
    else if (dl_cnt != '0)
      dl_cnt <= dl_cnt - 1'b1;
  end

  assign download_reset = downloading || (dl_cnt != '0);

  always_ff @(posedge clk) begin
    if (reset_nes)
      init_reset <= 1'b1;
    else if (downloading)
      init_reset <= 1'b0;  // First byte stream releases it
  end

  // Loader only runs inside the download window
  assign loader_reset = !download_reset;

  // Failed load keeps the console parked
  assign core_reset = init_reset || user_reset || download_reset || ld.error;

  // Follows the loader while done is up, then holds
  always_ff @(posedge clk) begin
    if (done)
      cart_flags <= flags;
  end

endmodule

// ==== design/joypad_serializer.sv ====
// Two NES controller shift registers fed from host button bytes
// Menu start/select requests stay pressed for hold_cycles cycles

`timescale 1ns/10ps

module joypad_serializer #(
  parameter int hold_cycles = 11_000_000  // About half a second at 21 MHz
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] joy_a,
  input  logic [7:0] joy_b,
  input  logic       start_req,
  input  logic       select_req,
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,
  output logic [1:0] joypad_data
);

  typedef logic [$clog2(hold_cycles + 1)-1:0] hold_t;

  hold_t      hold_cnt [2];  // 0 start, 1 select
  logic [1:0] hold_req;
  logic [1:0] held;
  logic [7:0] pad_in [2];    // Remapped button bytes
  logic [7:0] shreg [2];     // One per controller port
  logic [1:0] last_clock;    // Previous joypad_clock for edge detect

  // Host bit i lands on NES bit 7-i
  function automatic logic [7:0] bit_reverse(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[7-i] = b[i];
    end
    return r;
  endfunction

  assign hold_req = {select_req, start_req};

  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (reset)
        hold_cnt[k] <= '0;
      else if (hold_req[k])
        hold_cnt[k] <= hold_t'(hold_cycles);  // Retrigger restarts the window
      else if (hold_cnt[k] != '0)
        hold_cnt[k] <= hold_cnt[k] - 1'b1;
    end
  end

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      held[k] = (hold_cnt[k] != '0);
    end
  end

  // Controller 0 from joy_b with menu buttons merged, controller 1 from joy_a
  assign pad_in[0] = reset ? 8'h00 : bit_reverse(joy_b) | {4'b0000, held[0], held[1], 2'b00};
  assign pad_in[1] = reset ? 8'h00 : bit_reverse(joy_a);

  always_ff @(posedge clk) begin
    if (reset) begin
      shreg[0]   <= 8'h00;
      shreg[1]   <= 8'h00;
      last_clock <= 2'b00;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (joypad_strobe)
          shreg[k] <= pad_in[k];
        // Falling edge wins over a load in the same cycle
        if (!joypad_clock[k] && last_clock[k])
          shreg[k] <= {1'b0, shreg[k][7:1]};  // Zero fill after 8 bits
      end
      last_clock <= joypad_clock;
    end
  end

  assign joypad_data = {shreg[1][0], shreg[0][0]};

endmodule

// ==== design/nes_cart_top.sv ====
// Cartridge load and controller path of the console core
// Host streams the iNES image in; memory and reset lines go to the console

`timescale 1ns/10ps

module nes_cart_top import nes_cart_pkg::*; #(
  parameter int hold_cycles = 11_000_000  // Menu button hold, clock dependent
) (
  input  logic                  clk,
  input  logic                  reset_nes,
  input  logic                  downloading,
  input  logic [7:0]            indata,
  input  logic                  indata_clk,
  input  logic                  invert_mirroring,
  input  logic                  user_reset,
  input  logic [MEM_ADDR_W-1:0] cpu_addr,
  input  logic [7:0]            cpu_dout,
  input  logic                  cpu_write,
  input  logic [7:0]            joy_a,
  input  logic [7:0]            joy_b,
  input  logic                  start_req,
  input  logic                  select_req,
  input  logic                  joypad_strobe,
  input  logic [1:0]            joypad_clock,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic [7:0]            mem_din,
  output logic                  mem_we,
  output logic                  slot_run,
  output logic                  core_reset,
  output logic                  loader_done,
  output logic                  loader_error,
  output logic [31:0]           cart_flags,
  output logic [1:0]            joypad_data
);

  load_mem_if  ld ();
  logic        loader_reset;
  cart_flags_t loader_flags;  // Live from the header
  cart_flags_t cart_cfg;      // Latched for the console

  ines_game_loader u_loader (
    .clk              (clk),
    .reset            (loader_reset),
    .indata           (indata),
    .indata_clk       (indata_clk),
    .invert_mirroring (invert_mirroring),
    .mem              (ld.loader),
    .done             (loader_done),
    .flags            (loader_flags)
  );

  loader_mem_port u_mem_port (
    .clk         (clk),
    .reset_nes   (reset_nes),
    .ld          (ld.port),
    .downloading (downloading),
    .cpu_addr    (cpu_addr),
    .cpu_dout    (cpu_dout),
    .cpu_write   (cpu_write),
    .mem_addr    (mem_addr),
    .mem_din     (mem_din),
    .mem_we      (mem_we),
    .slot_run    (slot_run)
  );

  core_reset_control u_reset_ctrl (
    .clk          (clk),
    .reset_nes    (reset_nes),
    .downloading  (downloading),
    .user_reset   (user_reset),
    .ld           (ld.ctrl),
    .done         (loader_done),
    .flags        (loader_flags),
    .loader_reset (loader_reset),
    .core_reset   (core_reset),
    .cart_flags   (cart_cfg)
  );

  // Pads reset with the console
  joypad_serializer #(.hold_cycles(hold_cycles)) u_joypad (
    .clk           (clk),
    .reset         (core_reset),
    .joy_a         (joy_a),
    .joy_b         (joy_b),
    .start_req     (start_req),
    .select_req    (select_req),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

  assign loader_error = ld.error;
  assign cart_flags   = cart_cfg;

endmodule

// ==== verification/tb_nes_cart_top.sv ====
// Self-checking testbench for the cartridge loader and joypad path
// Streams iNES images into the DUT, scoreboards memory writes, checks flags and pads

`timescale 1ns/10ps

module tb_nes_cart_top import nes_cart_pkg::*; ();

  localparam int HOLD_CYCLES = 40;  // Short menu hold for simulation
  localparam int PRG_PAGE    = 1 << PRG_PAGE_SHIFT;
  localparam int CHR_PAGE    = 1 << CHR_PAGE_SHIFT;
  // Good load, dirty header, iNES 2.0, then two rejected headers with 16 tail bytes
  localparam int TOTAL_BYTES = (16 + PRG_PAGE + CHR_PAGE) + (16 + PRG_PAGE) +
                               (16 + PRG_PAGE + 2 * CHR_PAGE) + 2 * (16 + 16);

  logic                  clk;
  logic                  reset_nes;
  logic                  downloading;
  logic [7:0]            indata;
  logic                  indata_clk;
  logic                  invert_mirroring;
  logic                  user_reset;
  logic [MEM_ADDR_W-1:0] cpu_addr;
  logic [7:0]            cpu_dout;
  logic                  cpu_write;
  logic [7:0]            joy_a;
  logic [7:0]            joy_b;
  logic                  start_req;
  logic                  select_req;
  logic                  joypad_strobe;
  logic [1:0]            joypad_clock;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [7:0]            mem_din;
  logic                  mem_we;
  logic                  slot_run;
  logic                  core_reset;
  logic                  loader_done;
  logic                  loader_error;
  logic [31:0]           cart_flags;
  logic [1:0]            joypad_data;

  logic [15:0]           lfsr;          // Stimulus generator state
  logic [7:0]            hdr [16];      // Header of the image being built
  logic [MEM_ADDR_W-1:0] exp_addr_q [$];
  logic [7:0]            exp_data_q [$];
  string                 test_name;

  nes_cart_top #(.hold_cycles(HOLD_CYCLES)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 50 MHz
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_flags(input string name, input cart_flags_t exp, input cart_flags_t act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_mem_write(input string name, input logic [MEM_ADDR_W-1:0] exp_addr,
                                 input logic [7:0] exp_data,
                                 input logic [MEM_ADDR_W-1:0] act_addr,
                                 input logic [7:0] act_data);
    if (act_addr !== exp_addr || act_data !== exp_data)
      abort_run($sformatf("[FAIL] %s: expected %h/%h, actual %h/%h",
                          name, exp_addr, exp_data, act_addr, act_data));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);  // One step per bit
      b[i] = lfsr[0];
    end
  endtask

  // Smallest n with pages <= 2^n up to 7
  function automatic logic [2:0] page_code(input logic [7:0] pages);
    int n;
    n = 0;
    while (n < 7 && int'(pages) > (1 << n))
      n++;
    return 3'(n);
  endfunction

  // Expected configuration word for the header in hdr
  function automatic cart_flags_t predict_flags(input logic inv);
    cart_flags_t f;
    logic        any_extra;
    logic        dirty;
    any_extra = 1'b0;
    for (int i = 8; i < 16; i++)
      any_extra = any_extra | (hdr[i] != 8'h00);
    dirty         = (hdr[7][3:2] != 2'b10) && any_extra;  // Not iNES 2.0
    f             = '0;
    f.four_screen = hdr[6][3];
    f.chr_ram     = (hdr[5] == 8'h00);
    f.mirroring   = hdr[6][0] ^ inv;
    f.chr_size    = page_code(hdr[5]);
    f.prg_size    = page_code(hdr[4]);
    f.mapper      = {dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
    return f;
  endfunction

  // Host bit i shows up as NES bit 7-i with menu buttons merged
  function automatic logic [7:0] expected_pad(input logic [7:0] host, input logic start,
                                              input logic sel);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[7 - i] = host[i];
    r[3] = r[3] | start;
    r[2] = r[2] | sel;
    return r;
  endfunction

  task automatic fill_header(input logic [7:0] prg, input logic [7:0] chr,
                             input logic [7:0] f6, input logic [7:0] f7);
    for (int i = 0; i < 16; i++)
      hdr[i] = 8'h00;
    for (int i = 0; i < 4; i++)
      hdr[i] = INES_MAGIC[i];
    hdr[4] = prg;
    hdr[5] = chr;
    hdr[6] = f6;
    hdr[7] = f7;
  endtask

  // One strobe every 6 cycles
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    indata     = b;
    indata_clk = 1'b1;
    @(negedge clk);
    indata_clk = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic load_image(input string name, input logic expect_ok);
    logic [7:0] b;
    int         n_prg;
    int         n_chr;
    int         waited;
    test_name = name;
    n_prg     = int'(hdr[4]) << PRG_PAGE_SHIFT;
    n_chr     = int'(hdr[5]) << CHR_PAGE_SHIFT;
    @(negedge clk);
    downloading = 1'b1;
    for (int i = 0; i < 16; i++)
      send_byte(hdr[i]);
    if (expect_ok) begin
      for (int j = 0; j < n_prg; j++) begin
        rand_byte(b);
        exp_addr_q.push_back(PRG_BASE + MEM_ADDR_W'(j));
        exp_data_q.push_back(b);
        send_byte(b);
      end
      for (int j = 0; j < n_chr; j++) begin
        rand_byte(b);
        exp_addr_q.push_back(CHR_BASE + MEM_ADDR_W'(j));
        exp_data_q.push_back(b);
        send_byte(b);
      end
    end else begin
      for (int j = 0; j < 16; j++) begin  // Tail that must not reach memory
        rand_byte(b);
        send_byte(b);
      end
    end
    waited = 0;
    while (!loader_done) begin
      @(negedge clk);
      waited++;
      if (waited > 100)
        abort_run($sformatf("%s: loader_done never rose after the last byte", name));
    end
    check_bit({name, " error"}, !expect_ok, loader_error);
    check_bit({name, " core_reset"}, 1'b1, core_reset);
    repeat (2 * SLOT_PHASES) @(negedge clk);  // Last held write drains
    if (exp_addr_q.size() != 0)
      abort_run($sformatf("%s: %0d memory writes never appeared", name, exp_addr_q.size()));
    if (expect_ok)
      check_flags({name, " flags"}, predict_flags(invert_mirroring), cart_flags_t'(cart_flags));
    downloading = 1'b0;
    // Error only clears once the loader is back in reset
    waited = expect_ok ? DL_RESET_CYCLES : DL_RESET_CYCLES + 1;
    repeat (waited - 1) @(negedge clk);
    check_bit({name, " reset held"}, 1'b1, core_reset);
    @(negedge clk);
    check_bit({name, " reset released"}, 1'b0, core_reset);
  endtask

  // Strobe both pads, then clock out 8 bits and two fill zeros
  task automatic serialize_pads(input logic [7:0] exp0, input logic [7:0] exp1);
    @(negedge clk);
    joypad_strobe = 1'b1;
    @(negedge clk);
    joypad_strobe = 1'b0;
    for (int i = 0; i < 10; i++) begin
      check_bit($sformatf("%s pad0 bit %0d", test_name, i), (i < 8) ? exp0[i] : 1'b0,
                joypad_data[0]);
      check_bit($sformatf("%s pad1 bit %0d", test_name, i), (i < 8) ? exp1[i] : 1'b0,
                joypad_data[1]);
      joypad_clock = 2'b11;
      @(negedge clk);
      joypad_clock = 2'b00;  // Shift on this falling edge
      @(negedge clk);
    end
  endtask

  // Memory scoreboard for loader traffic only
  always @(posedge clk) begin
    if (downloading && mem_we) begin
      if (exp_addr_q.size() == 0) begin
        abort_run($sformatf("%s: unexpected memory write to %h", test_name, mem_addr));
      end else begin
        check_mem_write({test_name, " mem write"}, exp_addr_q[0], exp_data_q[0],
                        mem_addr, mem_din);
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  initial begin
    repeat (TOTAL_BYTES * 6 + 5000) @(posedge clk);
    abort_run("Timeout: the run took longer than the whole test sequence allows");
  end

  initial begin
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    cart_flags_t got_flags;
    reset_nes        = 1'b1;
    downloading      = 1'b0;
    indata           = 8'h00;
    indata_clk       = 1'b0;
    invert_mirroring = 1'b0;
    user_reset       = 1'b0;
    cpu_addr         = '0;
    cpu_dout         = 8'h00;
    cpu_write        = 1'b0;
    joy_a            = 8'h00;
    joy_b            = 8'h00;
    start_req        = 1'b0;
    select_req       = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock     = 2'b00;
    lfsr             = 16'd88;
    test_name        = "reset";
    repeat (4) @(negedge clk);
    reset_nes = 1'b0;
    @(negedge clk);
    check_bit("reset mem_we", 1'b0, mem_we);
    check_bit("reset core_reset", 1'b1, core_reset);  // Held until first download
    check_bit("reset done", 1'b0, loader_done);
    check_bit("reset error", 1'b0, loader_error);
    check_bit("reset pad0", 1'b0, joypad_data[0]);
    check_bit("reset pad1", 1'b0, joypad_data[1]);

    // Phase was 0 during reset and has stepped once, slot every fourth cycle
    test_name = "slot phase";
    for (int i = 1; i <= 2 * SLOT_PHASES; i++) begin
      check_bit($sformatf("slot_run cycle %0d", i), (i % SLOT_PHASES) == SLOT_PHASES - 1,
                slot_run);
      @(negedge clk);
    end

    // Console traffic passes straight through
    test_name = "passthrough";
    for (int i = 0; i < 4; i++) begin
      rand_byte(b0);
      rand_byte(b1);
      rand_byte(b2);
      @(negedge clk);
      cpu_addr  = {b2[5:0], b1, b0};
      cpu_dout  = b0 ^ b1;
      cpu_write = i[0];
      @(posedge clk);
      check_mem_write("passthrough bus", cpu_addr, cpu_dout, mem_addr, mem_din);
      check_bit("passthrough we", cpu_write, mem_we);
    end
    @(negedge clk);
    cpu_write = 1'b0;

    fill_header(8'd1, 8'd1, 8'h01, 8'h00);
    load_image("valid load", 1'b1);

    // Mapper nibble in byte 7 wiped by junk in bytes 8..15
    invert_mirroring = 1'b1;
    fill_header(8'd1, 8'd0, 8'h11, 8'h40);
    hdr[12] = 8'h55;
    load_image("dirty header", 1'b1);
    got_flags = cart_flags;
    check_bit("dirty chr_ram", 1'b1, got_flags.chr_ram);
    check_bit("dirty mapper high", 1'b0, |got_flags.mapper[7:4]);

    invert_mirroring = 1'b0;
    fill_header(8'd1, 8'd2, 8'h28, 8'h48);  // iNES 2.0 marker in byte 7
    hdr[9] = 8'h01;
    load_image("ines2 header", 1'b1);
    got_flags = cart_flags;
    check_bit("ines2 mapper high", 1'b1, got_flags.mapper[6]);

    fill_header(8'd1, 8'd1, 8'h00, 8'h00);
    hdr[1] = 8'h58;
    load_image("bad magic", 1'b0);
    fill_header(8'd1, 8'd1, 8'h04, 8'h00);  // Trainer bit
    load_image("trainer", 1'b0);

    test_name = "joypad";
    rand_byte(b0);
    rand_byte(b1);
    joy_a = b0;
    joy_b = b1;
    serialize_pads(expected_pad(joy_b, 1'b0, 1'b0), expected_pad(joy_a, 1'b0, 1'b0));

    // Start pressed bit cleared so the held value is visible
    test_name = "start hold";
    rand_byte(b0);
    rand_byte(b1);
    joy_a = b0;
    joy_b = b1 & 8'hCF;
    @(negedge clk);
    start_req = 1'b1;
    @(negedge clk);
    start_req = 1'b0;
    serialize_pads(expected_pad(joy_b, 1'b1, 1'b0), expected_pad(joy_a, 1'b0, 1'b0));
    repeat (HOLD_CYCLES + 4) @(negedge clk);  // Well past the window
    test_name = "start expired";
    serialize_pads(expected_pad(joy_b, 1'b0, 1'b0), expected_pad(joy_a, 1'b0, 1'b0));

    if (exp_addr_q.size() != 0) begin
      abort_run("Expected memory writes were left over at the end");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
design/nes_cart_pkg.sv
design/load_mem_if.sv
design/ines_game_loader.sv
design/loader_mem_port.sv
design/core_reset_control.sv
design/joypad_serializer.sv
design/nes_cart_top.sv
verification/tb_nes_cart_top.sv
